// File: rtl/vfpga_cq_track.sv
`timescale 1ns/1ns

module vfpga_cq_track (
    input  logic                            aclk,
    input  logic                            rst_n,
    input  vfpga_pkg::cq_desc_t             cq_rd,
    input  logic                            cq_rd_valid,
    output logic                            cq_rd_ready,
    input  vfpga_pkg::cq_desc_t             cq_wr,
    input  logic                            cq_wr_valid,
    output logic                            cq_wr_ready,
    output vfpga_pkg::notify_t              notify,
    output logic                            notify_valid,
    input  logic                            notify_ready,
    output logic [vfpga_pkg::cnt_w-1:0]     cpl_rd_cnt,
    output logic [vfpga_pkg::cnt_w-1:0]     cpl_wr_cnt
);

    logic rd_hs;
    logic wr_hs;

    // Read completions are never stalled
    assign cq_rd_ready = 1'b1;

    assign rd_hs = cq_rd_valid && cq_rd_ready;
    assign wr_hs = cq_wr_valid && cq_wr_ready;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            cpl_rd_cnt <= '0;
        end else if (rd_hs) begin
            cpl_rd_cnt <= cpl_rd_cnt + 1'b1;
        end
    end

    // Write completion turns into a notification, queue stalls until it is taken
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            cpl_wr_cnt   <= '0;
            notify_valid <= 1'b0;
            cq_wr_ready  <= 1'b0;
        end else if (wr_hs) begin
            cpl_wr_cnt   <= cpl_wr_cnt + 1'b1;
            notify_valid <= 1'b1;
            cq_wr_ready  <= 1'b0;
        end else if (notify_valid && notify_ready) begin
            notify_valid <= 1'b0;
            cq_wr_ready  <= 1'b1;
        end else if (!notify_valid) begin
            cq_wr_ready  <= 1'b1;
        end
    end

    // Tag zero-extended into the notification value
    always_ff @(posedge aclk) begin
        if (wr_hs) begin
            notify.value <= {{(vfpga_pkg::notify_w - vfpga_pkg::tag_w){1'b0}}, cq_wr.tag};
        end
    end

    // The completion tag on the read queue only matters to the shell
    a_cq_rd_known: assert property (@(posedge aclk) disable iff (!rst_n)
        cq_rd_valid |-> !$isunknown(cq_rd.tag));
    a_notify_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        notify_valid && !notify_ready |=> notify_valid && $stable(notify));

endmodule

// File: rtl/vfpga_ctrl_regs.sv
`timescale 1ns/1ns

module vfpga_ctrl_regs (
    input  logic                            aclk,
    input  logic                            rst_n,
    input  vfpga_pkg::axil_req_t            axil_req,
    output vfpga_pkg::axil_rsp_t            axil_rsp,
    output logic                            doorbell,
    output logic [vfpga_pkg::vaddr_w-1:0]   vaddr,
    output logic [vfpga_pkg::len_w-1:0]     len,
    input  logic                            busy,
    input  logic [vfpga_pkg::cnt_w-1:0]     cpl_rd_cnt,
    input  logic [vfpga_pkg::cnt_w-1:0]     cpl_wr_cnt,
    input  logic [vfpga_pkg::cnt_w-1:0]     beat_cnt
);

    logic                               wr_hs;
    logic                               ar_hs;
    logic                               bvalid;
    logic                               rvalid;
    logic                               arready;
    logic [vfpga_pkg::axil_data_w-1:0]  rdata;
    logic [vfpga_pkg::axil_data_w-1:0]  rd_mux;

    // Address and data are taken together, one write in flight
    assign wr_hs = axil_req.awvalid && axil_req.wvalid && !bvalid;
    assign ar_hs = axil_req.arvalid && arready;

    assign doorbell = wr_hs && (axil_req.awaddr == vfpga_pkg::reg_doorbell) &&
                      axil_req.wstrb[0] && axil_req.wdata[0];

    // Descriptor registers with byte enables
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            vaddr <= '0;
            len   <= '0;
        end else if (wr_hs) begin
            case (axil_req.awaddr)
                vfpga_pkg::reg_vaddr_lo: begin
                    for (int b = 0; b < 4; b++) begin
                        if (axil_req.wstrb[b]) begin
                            vaddr[8*b +: 8] <= axil_req.wdata[8*b +: 8];
                        end
                    end
                end
                vfpga_pkg::reg_vaddr_hi: begin
                    for (int b = 0; b < 2; b++) begin
                        if (axil_req.wstrb[b]) begin
                            vaddr[32+8*b +: 8] <= axil_req.wdata[8*b +: 8];
                        end
                    end
                end
                vfpga_pkg::reg_len: begin
                    for (int b = 0; b < 3; b++) begin
                        if (axil_req.wstrb[b]) begin
                            len[8*b +: 8] <= axil_req.wdata[8*b +: 8];
                        end
                    end
                    // Top byte carries only four length bits
                    if (axil_req.wstrb[3]) begin
                        len[vfpga_pkg::len_w-1:24] <= axil_req.wdata[vfpga_pkg::len_w-1:24];
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // Write response
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            bvalid <= 1'b0;
        end else if (wr_hs) begin
            bvalid <= 1'b1;
        end else if (axil_req.bready) begin
            bvalid <= 1'b0;
        end
    end

    // Read channel, arready comes back once the data has gone
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid  <= 1'b0;
            arready <= 1'b0;
        end else if (ar_hs) begin
            rvalid  <= 1'b1;
            arready <= 1'b0;
        end else if (rvalid && axil_req.rready) begin
            rvalid  <= 1'b0;
            arready <= 1'b1;
        end else if (!rvalid) begin
            arready <= 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (ar_hs) begin
            rdata <= rd_mux;
        end
    end

    always_comb begin
        rd_mux = '0;
        case (axil_req.araddr)
            vfpga_pkg::reg_vaddr_lo: rd_mux = vaddr[31:0];
            vfpga_pkg::reg_vaddr_hi: rd_mux[15:0] = vaddr[vfpga_pkg::vaddr_w-1:32];
            vfpga_pkg::reg_len:      rd_mux[vfpga_pkg::len_w-1:0] = len;
            vfpga_pkg::reg_cpl_rd:   rd_mux = cpl_rd_cnt;
            vfpga_pkg::reg_cpl_wr:   rd_mux = cpl_wr_cnt;
            vfpga_pkg::reg_beats:    rd_mux = beat_cnt;
            vfpga_pkg::reg_status:   rd_mux[0] = busy;
            default:                 rd_mux = '0;
        endcase
    end

    always_comb begin
        axil_rsp.awready = wr_hs;
        axil_rsp.wready  = wr_hs;
        axil_rsp.bvalid  = bvalid;
        axil_rsp.bresp   = vfpga_pkg::resp_okay;
        axil_rsp.arready = arready;
        axil_rsp.rvalid  = rvalid;
        axil_rsp.rdata   = rdata;
        axil_rsp.rresp   = vfpga_pkg::resp_okay;
    end

    // Responses hold until the master takes them
    a_bvalid_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        bvalid && !axil_req.bready |=> bvalid);
    a_rvalid_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        rvalid && !axil_req.rready |=> rvalid && $stable(rdata));

endmodule

// File: rtl/vfpga_pkg.sv
package vfpga_pkg;

    // Control bus
    localparam int axil_addr_w = 6;
    localparam int axil_data_w = 32;
    localparam int axil_strb_w = axil_data_w / 8;

    // Descriptor fields
    localparam int vaddr_w = 48;
    localparam int len_w   = 28;
    localparam int tag_w   = 6;

    // Host stream
    localparam int axis_data_w = 64;
    localparam int axis_keep_w = axis_data_w / 8;

    // Status counters and notification value
    localparam int cnt_w    = 32;
    localparam int notify_w = 32;

    localparam logic [1:0] resp_okay = 2'b00;

    // Register map
    localparam logic [axil_addr_w-1:0] reg_doorbell = 6'h00;
    localparam logic [axil_addr_w-1:0] reg_vaddr_lo = 6'h04;
    localparam logic [axil_addr_w-1:0] reg_vaddr_hi = 6'h08;
    localparam logic [axil_addr_w-1:0] reg_len      = 6'h0C;
    localparam logic [axil_addr_w-1:0] reg_cpl_rd   = 6'h10;
    localparam logic [axil_addr_w-1:0] reg_cpl_wr   = 6'h14;
    localparam logic [axil_addr_w-1:0] reg_beats    = 6'h18;
    localparam logic [axil_addr_w-1:0] reg_status   = 6'h1C;

    typedef struct packed {
        logic [axil_addr_w-1:0] awaddr;
        logic                   awvalid;
        logic [axil_data_w-1:0] wdata;
        logic [axil_strb_w-1:0] wstrb;
        logic                   wvalid;
        logic                   bready;
        logic [axil_addr_w-1:0] araddr;
        logic                   arvalid;
        logic                   rready;
    } axil_req_t;

    typedef struct packed {
        logic                   awready;
        logic                   wready;
        logic                   bvalid;
        logic [1:0]             bresp;
        logic                   arready;
        logic                   rvalid;
        logic [axil_data_w-1:0] rdata;
        logic [1:0]             rresp;
    } axil_rsp_t;

    typedef struct packed {
        logic [vaddr_w-1:0] vaddr;
        logic [len_w-1:0]   len;
        logic [tag_w-1:0]   tag;
    } sq_desc_t;

    typedef struct packed {
        logic [tag_w-1:0] tag;
    } cq_desc_t;

    typedef struct packed {
        logic [notify_w-1:0] value;
    } notify_t;

    typedef struct packed {
        logic [axis_data_w-1:0] tdata;
        logic [axis_keep_w-1:0] tkeep;
        logic                   tlast;
    } axis_beat_t;

endpackage

// File: rtl/vfpga_sq_issue.sv
`timescale 1ns/1ns

module vfpga_sq_issue (
    input  logic                            aclk,
    input  logic                            rst_n,
    input  logic                            doorbell,
    input  logic [vfpga_pkg::vaddr_w-1:0]   vaddr,
    input  logic [vfpga_pkg::len_w-1:0]     len,
    output logic                            busy,
    output vfpga_pkg::sq_desc_t             sq_rd,
    output logic                            sq_rd_valid,
    input  logic                            sq_rd_ready,
    output vfpga_pkg::sq_desc_t             sq_wr,
    output logic                            sq_wr_valid,
    input  logic                            sq_wr_ready
);

    logic                           accept;
    logic                           rd_pend;
    logic                           wr_pend;
    logic [vfpga_pkg::tag_w-1:0]    tag_q;
    vfpga_pkg::sq_desc_t            desc_q;

    assign busy   = rd_pend || wr_pend;
    // Doorbells while busy are dropped
    assign accept = doorbell && !busy;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            rd_pend <= 1'b0;
            wr_pend <= 1'b0;
            tag_q   <= '0;
        end else if (accept) begin
            rd_pend <= 1'b1;
            wr_pend <= 1'b1;
            tag_q   <= tag_q + 1'b1;
        end else begin
            // Each queue retires on its own handshake
            if (rd_pend && sq_rd_ready) begin
                rd_pend <= 1'b0;
            end
            if (wr_pend && sq_wr_ready) begin
                wr_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            desc_q <= '{vaddr: vaddr, len: len, tag: tag_q};
        end
    end

    assign sq_rd       = desc_q;
    assign sq_rd_valid = rd_pend;
    assign sq_wr       = desc_q;
    assign sq_wr_valid = wr_pend;

    a_sq_rd_stable: assert property (@(posedge aclk) disable iff (!rst_n)
        sq_rd_valid && !sq_rd_ready |=> sq_rd_valid && $stable(sq_rd));
    a_sq_wr_stable: assert property (@(posedge aclk) disable iff (!rst_n)
        sq_wr_valid && !sq_wr_ready |=> sq_wr_valid && $stable(sq_wr));

endmodule

// File: rtl/vfpga_stream_loop.sv
`timescale 1ns/1ns

module vfpga_stream_loop (
    input  logic                            aclk,
    input  logic                            rst_n,
    input  vfpga_pkg::axis_beat_t           host_recv,
    input  logic                            host_recv_valid,
    output logic                            host_recv_ready,
    output vfpga_pkg::axis_beat_t           host_send,
    output logic                            host_send_valid,
    input  logic                            host_send_ready,
    output logic [vfpga_pkg::cnt_w-1:0]     beat_cnt
);

    vfpga_pkg::axis_beat_t  mem [2];
    logic                   wr_ptr;
    logic                   rd_ptr;
    logic [1:0]             count;
    logic [1:0]             count_n;
    logic                   push;
    logic                   pop;

    assign push = host_recv_valid && host_recv_ready;
    assign pop  = host_send_valid && host_send_ready;

    assign host_send_valid = (count != 2'd0);
    assign host_send       = mem[rd_ptr];

    always_comb begin
        count_n = count;
        if (push && !pop) begin
            count_n = count + 2'd1;
        end else if (pop && !push) begin
            count_n = count - 2'd1;
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            count           <= 2'd0;
            wr_ptr          <= 1'b0;
            rd_ptr          <= 1'b0;
            host_recv_ready <= 1'b0;
        end else begin
            count <= count_n;
            // Registered ready, drops once both entries hold a beat
            host_recv_ready <= (count_n != 2'd2);
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= host_recv;
        end
    end

    // Beats counted as they leave
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (pop) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    a_send_stable: assert property (@(posedge aclk) disable iff (!rst_n)
        host_send_valid && !host_send_ready |=> host_send_valid && $stable(host_send));

endmodule

// File: rtl/vfpga_top.sv
`timescale 1ns/1ns

module vfpga_top (
    input  logic                        aclk,
    input  logic                        rst_n,

    // Control port
    input  vfpga_pkg::axil_req_t        axil_req,
    output vfpga_pkg::axil_rsp_t        axil_rsp,

    // Submission queues
    output vfpga_pkg::sq_desc_t         sq_rd,
    output logic                        sq_rd_valid,
    input  logic                        sq_rd_ready,
    output vfpga_pkg::sq_desc_t         sq_wr,
    output logic                        sq_wr_valid,
    input  logic                        sq_wr_ready,

    // Completion queues
    input  vfpga_pkg::cq_desc_t         cq_rd,
    input  logic                        cq_rd_valid,
    output logic                        cq_rd_ready,
    input  vfpga_pkg::cq_desc_t         cq_wr,
    input  logic                        cq_wr_valid,
    output logic                        cq_wr_ready,

    output vfpga_pkg::notify_t          notify,
    output logic                        notify_valid,
    input  logic                        notify_ready,

    // Host stream
    input  vfpga_pkg::axis_beat_t       host_recv,
    input  logic                        host_recv_valid,
    output logic                        host_recv_ready,
    output vfpga_pkg::axis_beat_t       host_send,
    output logic                        host_send_valid,
    input  logic                        host_send_ready
);

    logic                               doorbell;
    logic                               busy;
    logic [vfpga_pkg::vaddr_w-1:0]      vaddr;
    logic [vfpga_pkg::len_w-1:0]        len;
    logic [vfpga_pkg::cnt_w-1:0]        cpl_rd_cnt;
    logic [vfpga_pkg::cnt_w-1:0]        cpl_wr_cnt;
    logic [vfpga_pkg::cnt_w-1:0]        beat_cnt;

    vfpga_ctrl_regs i_ctrl_regs (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .axil_req   (axil_req),
        .axil_rsp   (axil_rsp),
        .doorbell   (doorbell),
        .vaddr      (vaddr),
        .len        (len),
        .busy       (busy),
        .cpl_rd_cnt (cpl_rd_cnt),
        .cpl_wr_cnt (cpl_wr_cnt),
        .beat_cnt   (beat_cnt)
    );

    vfpga_sq_issue i_sq_issue (
        .aclk        (aclk),
        .rst_n       (rst_n),
        .doorbell    (doorbell),
        .vaddr       (vaddr),
        .len         (len),
        .busy        (busy),
        .sq_rd       (sq_rd),
        .sq_rd_valid (sq_rd_valid),
        .sq_rd_ready (sq_rd_ready),
        .sq_wr       (sq_wr),
        .sq_wr_valid (sq_wr_valid),
        .sq_wr_ready (sq_wr_ready)
    );

    vfpga_cq_track i_cq_track (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .cq_rd        (cq_rd),
        .cq_rd_valid  (cq_rd_valid),
        .cq_rd_ready  (cq_rd_ready),
        .cq_wr        (cq_wr),
        .cq_wr_valid  (cq_wr_valid),
        .cq_wr_ready  (cq_wr_ready),
        .notify       (notify),
        .notify_valid (notify_valid),
        .notify_ready (notify_ready),
        .cpl_rd_cnt   (cpl_rd_cnt),
        .cpl_wr_cnt   (cpl_wr_cnt)
    );

    // User logic role, host stream loopback
    vfpga_stream_loop i_stream_loop (
        .aclk            (aclk),
        .rst_n           (rst_n),
        .host_recv       (host_recv),
        .host_recv_valid (host_recv_valid),
        .host_recv_ready (host_recv_ready),
        .host_send       (host_send),
        .host_send_valid (host_send_valid),
        .host_send_ready (host_send_ready),
        .beat_cnt        (beat_cnt)
    );

endmodule

// File: tests/tb_vfpga_top.sv
`timescale 1ns/1ns

module tb_vfpga_top;

    localparam int clk_period = 4;
    localparam int step_budget = 200;

    typedef enum logic [2:0] {
        op_write,
        op_read,
        op_desc,
        op_cpl,
        op_burst,
        op_stall,
        op_drain
    } op_t;

    // addr holds the register offset, the expected tag or the completion queue
    typedef struct packed {
        op_t                                op;
        logic [vfpga_pkg::axil_addr_w-1:0]  addr;
        logic [3:0]                         strb;
        logic [31:0]                        data;
        logic [63:0]                        exp;
    } step_t;

    logic                       aclk;
    logic                       rst_n;
    vfpga_pkg::axil_req_t       axil_req;
    vfpga_pkg::axil_rsp_t       axil_rsp;
    vfpga_pkg::sq_desc_t        sq_rd;
    logic                       sq_rd_valid;
    logic                       sq_rd_ready;
    vfpga_pkg::sq_desc_t        sq_wr;
    logic                       sq_wr_valid;
    logic                       sq_wr_ready;
    vfpga_pkg::cq_desc_t        cq_rd;
    logic                       cq_rd_valid;
    logic                       cq_rd_ready;
    vfpga_pkg::cq_desc_t        cq_wr;
    logic                       cq_wr_valid;
    logic                       cq_wr_ready;
    vfpga_pkg::notify_t         notify;
    logic                       notify_valid;
    logic                       notify_ready;
    vfpga_pkg::axis_beat_t      host_recv;
    logic                       host_recv_valid;
    logic                       host_recv_ready;
    vfpga_pkg::axis_beat_t      host_send;
    logic                       host_send_valid;
    logic                       host_send_ready;

    integer                     seed = 32'hf743;
    logic                       sq_stall;
    logic                       table_built;
    step_t                      table_q [$];
    vfpga_pkg::sq_desc_t        rd_desc_q [$];
    vfpga_pkg::sq_desc_t        wr_desc_q [$];
    logic [31:0]                exp_notify_q [$];
    vfpga_pkg::axis_beat_t      exp_beat_q [$];

    vfpga_top i_vfpga_top (
        .aclk            (aclk),
        .rst_n           (rst_n),
        .axil_req        (axil_req),
        .axil_rsp        (axil_rsp),
        .sq_rd           (sq_rd),
        .sq_rd_valid     (sq_rd_valid),
        .sq_rd_ready     (sq_rd_ready),
        .sq_wr           (sq_wr),
        .sq_wr_valid     (sq_wr_valid),
        .sq_wr_ready     (sq_wr_ready),
        .cq_rd           (cq_rd),
        .cq_rd_valid     (cq_rd_valid),
        .cq_rd_ready     (cq_rd_ready),
        .cq_wr           (cq_wr),
        .cq_wr_valid     (cq_wr_valid),
        .cq_wr_ready     (cq_wr_ready),
        .notify          (notify),
        .notify_valid    (notify_valid),
        .notify_ready    (notify_ready),
        .host_recv       (host_recv),
        .host_recv_valid (host_recv_valid),
        .host_recv_ready (host_recv_ready),
        .host_send       (host_send),
        .host_send_valid (host_send_valid),
        .host_send_ready (host_send_ready)
    );

    initial begin
        aclk = 1'b0;
        forever #(clk_period / 2) aclk = ~aclk;
    end

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            stop_run($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected));
        end
    endtask

    task automatic add_step(input op_t op, input logic [5:0] addr, input logic [3:0] strb,
                            input logic [31:0] data, input logic [63:0] exp);
        step_t s;
        s = '{op: op, addr: addr, strb: strb, data: data, exp: exp};
        table_q.push_back(s);
    endtask

    task automatic axil_write(input logic [5:0] addr, input logic [3:0] strb,
                              input logic [31:0] data);
        @(posedge aclk);
        #1;
        axil_req.awaddr  = addr;
        axil_req.wdata   = data;
        axil_req.wstrb   = strb;
        axil_req.awvalid = 1'b1;
        axil_req.wvalid  = 1'b1;
        axil_req.bready  = 1'b1;
        @(negedge aclk);
        while (!axil_rsp.awready) @(negedge aclk);
        check_value("wready", axil_rsp.wready, 1'b1);
        @(posedge aclk);
        #1;
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        @(negedge aclk);
        while (!axil_rsp.bvalid) @(negedge aclk);
        check_value("bresp", axil_rsp.bresp, 2'b00);
        @(posedge aclk);
        #1;
        axil_req.bready = 1'b0;
    endtask

    task automatic axil_read(input logic [5:0] addr, output logic [31:0] data);
        @(posedge aclk);
        #1;
        axil_req.araddr  = addr;
        axil_req.arvalid = 1'b1;
        axil_req.rready  = 1'b1;
        @(negedge aclk);
        while (!axil_rsp.arready) @(negedge aclk);
        @(posedge aclk);
        #1;
        axil_req.arvalid = 1'b0;
        @(negedge aclk);
        while (!axil_rsp.rvalid) @(negedge aclk);
        data = axil_rsp.rdata;
        check_value("rresp", axil_rsp.rresp, 2'b00);
        @(posedge aclk);
        #1;
        axil_req.rready = 1'b0;
    endtask

    task automatic expect_desc(input logic [5:0] tag, input logic [31:0] len,
                               input logic [63:0] vaddr);
        vfpga_pkg::sq_desc_t d_rd;
        vfpga_pkg::sq_desc_t d_wr;
        while (rd_desc_q.size() == 0 || wr_desc_q.size() == 0) @(negedge aclk);
        d_rd = rd_desc_q.pop_front();
        d_wr = wr_desc_q.pop_front();
        check_value("sq_rd.tag", d_rd.tag, tag);
        check_value("sq_rd.len", d_rd.len, len);
        check_value("sq_rd.vaddr", d_rd.vaddr, vaddr);
        check_value("sq_wr.tag", d_wr.tag, tag);
        check_value("sq_wr.len", d_wr.len, len);
        check_value("sq_wr.vaddr", d_wr.vaddr, vaddr);
    endtask

    task automatic send_cpl(input logic is_wr, input logic [5:0] tag);
        @(posedge aclk);
        #1;
        if (is_wr) begin
            exp_notify_q.push_back({26'd0, tag});
            cq_wr.tag   = tag;
            cq_wr_valid = 1'b1;
            @(negedge aclk);
            while (!cq_wr_ready) @(negedge aclk);
        end else begin
            cq_rd.tag   = tag;
            cq_rd_valid = 1'b1;
            @(negedge aclk);
            while (!cq_rd_ready) @(negedge aclk);
        end
        @(posedge aclk);
        #1;
        cq_rd_valid = 1'b0;
        cq_wr_valid = 1'b0;
    endtask

    task automatic send_burst(input int beats);
        vfpga_pkg::axis_beat_t beat;
        @(negedge aclk);
        for (int i = 0; i < beats; i++) begin
            beat.tdata = {$random(seed), $random(seed)};
            beat.tkeep = $random(seed);
            beat.tlast = (i == beats - 1);
            @(posedge aclk);
            #1;
            host_recv       = beat;
            host_recv_valid = 1'b1;
            exp_beat_q.push_back(beat);
            @(negedge aclk);
            while (!host_recv_ready) @(negedge aclk);
        end
        @(posedge aclk);
        #1;
        host_recv_valid = 1'b0;
    endtask

    task automatic wait_drained();
        while (exp_notify_q.size() != 0 || exp_beat_q.size() != 0) @(negedge aclk);
    endtask

    task automatic run_step(input step_t s);
        logic [31:0] rd_val;
        case (s.op)
            op_write: axil_write(s.addr, s.strb, s.data);
            op_read: begin
                axil_read(s.addr, rd_val);
                check_value($sformatf("rdata[0x%02h]", s.addr), rd_val, s.exp);
            end
            op_desc:  expect_desc(s.addr, s.data, s.exp);
            op_cpl:   send_cpl(s.addr[0], s.data[5:0]);
            op_burst: send_burst(s.data);
            op_stall: sq_stall = s.data[0];
            op_drain: wait_drained();
            default:  stop_run("Unknown operation in the test table");
        endcase
    endtask

    // Shell side ready patterns
    initial begin
        logic [31:0] ready_bits;
        forever begin
            @(posedge aclk);
            #1;
            ready_bits      = $random(seed);
            sq_rd_ready     = !sq_stall && ready_bits[0];
            sq_wr_ready     = !sq_stall && ready_bits[1];
            notify_ready    = ready_bits[2];
            host_send_ready = ready_bits[3] || ready_bits[4];
        end
    end

    // Monitors sample mid-cycle where handshakes are settled
    initial begin
        forever begin
            @(negedge aclk);
            if (sq_rd_valid && sq_rd_ready) begin
                rd_desc_q.push_back(sq_rd);
            end
            if (sq_wr_valid && sq_wr_ready) begin
                wr_desc_q.push_back(sq_wr);
            end
            if (notify_valid && notify_ready) begin
                if (exp_notify_q.size() == 0) begin
                    stop_run("A notification arrived with no write completion behind it");
                end else begin
                    check_value("notify.value", notify.value, exp_notify_q.pop_front());
                end
            end
            if (host_send_valid && host_send_ready) begin
                if (exp_beat_q.size() == 0) begin
                    stop_run("A stream beat left host_send that was never sent");
                end else begin
                    check_value("host_send.tdata", host_send.tdata, exp_beat_q[0].tdata);
                    check_value("host_send.tkeep", host_send.tkeep, exp_beat_q[0].tkeep);
                    check_value("host_send.tlast", host_send.tlast, exp_beat_q[0].tlast);
                    void'(exp_beat_q.pop_front());
                end
            end
        end
    end

    initial begin
        int limit_ns;
        wait (table_built);
        limit_ns = table_q.size() * step_budget * clk_period + 20 * clk_period;
        #(limit_ns);
        stop_run("Timeout: the test table did not complete in the allowed time");
    end

    initial begin
        rst_n           = 1'b0;
        axil_req        = '0;
        cq_rd           = '0;
        cq_rd_valid     = 1'b0;
        cq_wr           = '0;
        cq_wr_valid     = 1'b0;
        host_recv       = '0;
        host_recv_valid = 1'b0;
        sq_rd_ready     = 1'b0;
        sq_wr_ready     = 1'b0;
        notify_ready    = 1'b0;
        host_send_ready = 1'b0;
        sq_stall        = 1'b0;
        table_built     = 1'b0;

        // Reset values of every register
        for (int a = 0; a < 32; a += 4) begin
            add_step(op_read, a, 4'h0, 32'h0, 64'h0);
        end
        // Width masks, byte enables and read-only offsets
        add_step(op_write, vfpga_pkg::reg_vaddr_lo, 4'hF, 32'hDEADBEEF, 64'h0);
        add_step(op_read,  vfpga_pkg::reg_vaddr_lo, 4'h0, 32'h0, 64'hDEADBEEF);
        add_step(op_write, vfpga_pkg::reg_vaddr_hi, 4'hF, 32'hFFFF1234, 64'h0);
        add_step(op_read,  vfpga_pkg::reg_vaddr_hi, 4'h0, 32'h0, 64'h1234);
        add_step(op_write, vfpga_pkg::reg_len,      4'hF, 32'hFFFFFFFF, 64'h0);
        add_step(op_read,  vfpga_pkg::reg_len,      4'h0, 32'h0, 64'h0FFFFFFF);
        add_step(op_write, vfpga_pkg::reg_vaddr_lo, 4'h5, 32'h11223344, 64'h0);
        add_step(op_read,  vfpga_pkg::reg_vaddr_lo, 4'h0, 32'h0, 64'hDE22BE44);
        add_step(op_write, vfpga_pkg::reg_len,      4'h2, 32'h00000000, 64'h0);
        add_step(op_read,  vfpga_pkg::reg_len,      4'h0, 32'h0, 64'h0FFF00FF);
        add_step(op_write, vfpga_pkg::reg_cpl_rd,   4'hF, 32'h00000055, 64'h0);
        add_step(op_read,  vfpga_pkg::reg_cpl_rd,   4'h0, 32'h0, 64'h0);
        add_step(op_write, vfpga_pkg::reg_beats,    4'hF, 32'h000000AA, 64'h0);
        add_step(op_read,  vfpga_pkg::reg_beats,    4'h0, 32'h0, 64'h0);
        add_step(op_write, vfpga_pkg::reg_status,   4'hF, 32'h00000001, 64'h0);
        add_step(op_read,  vfpga_pkg::reg_status,   4'h0, 32'h0, 64'h0);
        // Doorbells and tags
        add_step(op_write, vfpga_pkg::reg_len,      4'hF, 32'h00000100, 64'h0);
        add_step(op_write, vfpga_pkg::reg_vaddr_hi, 4'hF, 32'h0000ABCD, 64'h0);
        add_step(op_write, vfpga_pkg::reg_vaddr_lo, 4'hF, 32'h10000000, 64'h0);
        add_step(op_write, vfpga_pkg::reg_doorbell, 4'hF, 32'h00000001, 64'h0);
        add_step(op_desc,  6'd0, 4'h0, 32'h00000100, 64'hABCD10000000);
        add_step(op_write, vfpga_pkg::reg_doorbell, 4'hF, 32'h00000000, 64'h0);
        add_step(op_write, vfpga_pkg::reg_vaddr_lo, 4'hF, 32'h20000040, 64'h0);
        add_step(op_write, vfpga_pkg::reg_doorbell, 4'hF, 32'h00000001, 64'h0);
        add_step(op_desc,  6'd1, 4'h0, 32'h00000100, 64'hABCD20000040);
        // Held queues keep the region busy so the next doorbell is dropped
        add_step(op_stall, 6'd0, 4'h0, 32'h1, 64'h0);
        add_step(op_write, vfpga_pkg::reg_doorbell, 4'hF, 32'h00000001, 64'h0);
        add_step(op_read,  vfpga_pkg::reg_status,   4'h0, 32'h0, 64'h1);
        add_step(op_write, vfpga_pkg::reg_len,      4'hF, 32'h00000040, 64'h0);
        add_step(op_write, vfpga_pkg::reg_doorbell, 4'hF, 32'h00000001, 64'h0);
        add_step(op_stall, 6'd0, 4'h0, 32'h0, 64'h0);
        add_step(op_desc,  6'd2, 4'h0, 32'h00000100, 64'hABCD20000040);
        add_step(op_read,  vfpga_pkg::reg_status,   4'h0, 32'h0, 64'h0);
        add_step(op_write, vfpga_pkg::reg_doorbell, 4'hF, 32'h00000001, 64'h0);
        add_step(op_desc,  6'd3, 4'h0, 32'h00000040, 64'hABCD20000040);
        // Completions and notifications
        for (int t = 0; t < 3; t++) begin
            add_step(op_cpl, 6'd0, 4'h0, t, 64'h0);
        end
        for (int t = 0; t < 4; t++) begin
            add_step(op_cpl, 6'd1, 4'h0, t, 64'h0);
        end
        add_step(op_drain, 6'd0, 4'h0, 32'h0, 64'h0);
        add_step(op_read,  vfpga_pkg::reg_cpl_rd,   4'h0, 32'h0, 64'd3);
        add_step(op_read,  vfpga_pkg::reg_cpl_wr,   4'h0, 32'h0, 64'd4);
        // Stream loopback
        add_step(op_burst, 6'd0, 4'h0, 32'd20, 64'h0);
        add_step(op_burst, 6'd0, 4'h0, 32'd7, 64'h0);
        add_step(op_drain, 6'd0, 4'h0, 32'h0, 64'h0);
        add_step(op_read,  vfpga_pkg::reg_beats,    4'h0, 32'h0, 64'd27);
        table_built = 1'b1;

        repeat (10) @(posedge aclk);
        #1;
        rst_n = 1'b1;

        check_value("sq_rd_valid", sq_rd_valid, 1'b0);
        check_value("sq_wr_valid", sq_wr_valid, 1'b0);
        check_value("notify_valid", notify_valid, 1'b0);
        check_value("host_send_valid", host_send_valid, 1'b0);
        check_value("bvalid", axil_rsp.bvalid, 1'b0);
        check_value("rvalid", axil_rsp.rvalid, 1'b0);
        check_value("cq_rd_ready", cq_rd_ready, 1'b1);

        foreach (table_q[i]) begin
            run_step(table_q[i]);
        end

        // Nothing extra may have been issued
        check_value("sq_rd descriptors left", rd_desc_q.size(), 0);
        check_value("sq_wr descriptors left", wr_desc_q.size(), 0);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: vlog.f
rtl/vfpga_pkg.sv
rtl/vfpga_ctrl_regs.sv
rtl/vfpga_sq_issue.sv
rtl/vfpga_cq_track.sv
rtl/vfpga_stream_loop.sv
rtl/vfpga_top.sv
tests/tb_vfpga_top.sv
